// File: dataPkg.sv
package dataPkg;

    // register and result width
    localparam int DATA_WIDTH = 16;
    localparam int REG_COUNT  = 4;

    typedef logic [1:0] regIdxT;

    // imm is zero-extended by the ALU
    typedef struct packed {
        logic [3:0] opcode;
        regIdxT     dest;
        regIdxT     srcA;
        regIdxT     srcB;
        logic [5:0] imm;
    } instrT;

    // valid only while done is high
    typedef struct packed {
        logic                  written;
        logic                  illegal;
        regIdxT                dest;
        logic [DATA_WIDTH-1:0] data;
    } wbResultT;

    // ALU_MUL selects the multiply accumulator
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_IMM,
        ALU_MUL
    } aluOpT;

endpackage

// File: ctrlPkg.sv
package ctrlPkg;

    import dataPkg::*;

    // number of shift-add iterations for a multiply
    localparam int MUL_STEPS = 16;

    // values 6 to 15 are undefined
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_LDI = 4'd4,
        OP_MUL = 4'd5
    } opcodeT;

    typedef enum logic [3:0] {
        S_IDLE,
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_LDI,
        S_MULINIT,
        S_MULSTEP,
        S_WRITE,
        S_ILLEGAL
    } microStateT;

    typedef struct packed {
        logic  irLoad;
        aluOpT aluOp;
        logic  accClear;
        logic  mulStep;
        logic  timerLoad;
        logic  timerRun;
        logic  regWrite;
        logic  busy;
        logic  done;
    } ctrlWordT;

    // everything off, used for idle and unknown states
    localparam ctrlWordT CTRL_IDLE = '{
        irLoad:    1'b0,
        aluOp:     ALU_ADD,
        accClear:  1'b0,
        mulStep:   1'b0,
        timerLoad: 1'b0,
        timerRun:  1'b0,
        regWrite:  1'b0,
        busy:      1'b0,
        done:      1'b0
    };

endpackage

// File: microStore.sv
`timescale 1ns/1ps

module microStore (
    input  ctrlPkg::microStateT state,
    input  ctrlPkg::opcodeT     opcode,
    output ctrlPkg::ctrlWordT   ctrl
);

    import dataPkg::*;
    import ctrlPkg::*;

    // undefined opcodes never reach exec or write, so the default is arbitrary
    function automatic aluOpT opToAlu(input opcodeT op);
        case (op)
            OP_ADD:  return ALU_ADD;
            OP_SUB:  return ALU_SUB;
            OP_AND:  return ALU_AND;
            OP_OR:   return ALU_OR;
            OP_LDI:  return ALU_IMM;
            OP_MUL:  return ALU_MUL;
            default: return ALU_ADD;
        endcase
    endfunction

    always_comb begin
        ctrl = CTRL_IDLE;
        case (state)
            S_IDLE: ctrl = CTRL_IDLE;
            S_FETCH: begin
                ctrl.busy   = 1'b1;
                ctrl.irLoad = 1'b1;
            end
            S_DECODE: ctrl.busy = 1'b1;
            S_EXEC: begin
                ctrl.busy  = 1'b1;
                ctrl.aluOp = opToAlu(opcode);
            end
            S_LDI: begin
                ctrl.busy  = 1'b1;
                ctrl.aluOp = ALU_IMM;
            end
            S_MULINIT: begin
                ctrl.busy      = 1'b1;
                ctrl.aluOp     = ALU_MUL;
                ctrl.accClear  = 1'b1;
                ctrl.timerLoad = 1'b1;
            end
            S_MULSTEP: begin
                ctrl.busy     = 1'b1;
                ctrl.aluOp    = ALU_MUL;
                ctrl.mulStep  = 1'b1;
                ctrl.timerRun = 1'b1;
            end
            // result must still be on the ALU output during writeback
            S_WRITE: begin
                ctrl.busy     = 1'b1;
                ctrl.aluOp    = opToAlu(opcode);
                ctrl.regWrite = 1'b1;
                ctrl.done     = 1'b1;
            end
            S_ILLEGAL: begin
                ctrl.busy = 1'b1;
                ctrl.done = 1'b1;
            end
            default: ctrl = CTRL_IDLE;
        endcase
    end

endmodule

// File: microSequencer.sv
`timescale 1ns/1ps

module microSequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  ctrlPkg::opcodeT     opcode,
    input  logic                timerLast,
    output ctrlPkg::microStateT state
);

    import ctrlPkg::*;

    microStateT nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            // start only counts while idle
            S_IDLE: begin
                if (start) begin
                    nextState = S_FETCH;
                end
            end
            S_FETCH: nextState = S_DECODE;
            S_DECODE: begin
                case (opcode)
                    OP_ADD, OP_SUB, OP_AND, OP_OR: nextState = S_EXEC;
                    OP_LDI:                        nextState = S_LDI;
                    OP_MUL:                        nextState = S_MULINIT;
                    default:                       nextState = S_ILLEGAL;
                endcase
            end
            S_EXEC:    nextState = S_WRITE;
            S_LDI:     nextState = S_WRITE;
            S_MULINIT: nextState = S_MULSTEP;
            // timerLast marks the final shift-add step
            S_MULSTEP: begin
                if (timerLast) begin
                    nextState = S_WRITE;
                end
            end
            S_WRITE:   nextState = S_IDLE;
            S_ILLEGAL: nextState = S_IDLE;
            default:   nextState = S_IDLE;
        endcase
    end

endmodule

// File: iterTimer.sv
`timescale 1ns/1ps

module iterTimer (
    input  logic clk,
    input  logic reset,
    input  logic load,
    input  logic run,
    output logic last
);

    import ctrlPkg::*;

    logic [4:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load) begin
            count <= 5'(MUL_STEPS);
        end else if (run && count != '0) begin
            count <= count - 5'd1;
        end
    end

    // high during the last multiply step
    assign last = (count == 5'd1);

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           writeEn,
    input  dataPkg::regIdxT                writeIdx,
    input  dataPkg::regIdxT                readIdxA,
    input  dataPkg::regIdxT                readIdxB,
    input  logic [dataPkg::DATA_WIDTH-1:0] writeData,
    output logic [dataPkg::DATA_WIDTH-1:0] readDataA,
    output logic [dataPkg::DATA_WIDTH-1:0] readDataB
);

    import dataPkg::*;

    logic [DATA_WIDTH-1:0] regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    // reads see the old value until the write edge
    assign readDataA = regs[readIdxA];
    assign readDataB = regs[readIdxB];

endmodule

// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic                           clk,
    input  logic                           reset,
    input  dataPkg::aluOpT                 aluOp,
    input  logic                           accClear,
    input  logic                           mulStep,
    input  logic [dataPkg::DATA_WIDTH-1:0] operandA,
    input  logic [dataPkg::DATA_WIDTH-1:0] operandB,
    input  logic [5:0]                     imm,
    output logic [dataPkg::DATA_WIDTH-1:0] aluResult
);

    import dataPkg::*;

    logic [DATA_WIDTH-1:0] multiplicand;
    logic [DATA_WIDTH-1:0] multiplier;
    logic [DATA_WIDTH-1:0] acc;

    // shift-add multiplier, one bit of the multiplier per step
    always_ff @(posedge clk) begin
        if (reset) begin
            multiplicand <= '0;
            multiplier   <= '0;
            acc          <= '0;
        end else if (accClear) begin
            multiplicand <= operandA;
            multiplier   <= operandB;
            acc          <= '0;
        end else if (mulStep) begin
            if (multiplier[0]) begin
                acc <= acc + multiplicand;
            end
            // high bits fall off, only the low half of the product is kept
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    always_comb begin
        case (aluOp)
            ALU_ADD: aluResult = operandA + operandB;
            ALU_SUB: aluResult = operandA - operandB;
            ALU_AND: aluResult = operandA & operandB;
            ALU_OR:  aluResult = operandA | operandB;
            ALU_IMM: aluResult = {{(DATA_WIDTH-6){1'b0}}, imm};
            ALU_MUL: aluResult = acc;
            default: aluResult = '0;
        endcase
    end

endmodule

// File: controlCore.sv
`timescale 1ns/1ps

module controlCore (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  dataPkg::instrT    instr,
    output logic              busy,
    output logic              done,
    output dataPkg::wbResultT result
);

    import dataPkg::*;
    import ctrlPkg::*;

    instrT                 ir;
    opcodeT                opcode;
    microStateT            state;
    ctrlWordT              ctrl;
    logic                  timerLast;
    logic [DATA_WIDTH-1:0] readDataA;
    logic [DATA_WIDTH-1:0] readDataB;
    logic [DATA_WIDTH-1:0] aluResult;

    // instruction register, captured in fetch
    always_ff @(posedge clk) begin
        if (ctrl.irLoad) begin
            ir <= instr;
        end
    end

    assign opcode = opcodeT'(ir.opcode);

    microSequencer uSeq (
        .clk(clk), .reset(reset), .start(start), .opcode(opcode),
        .timerLast(timerLast), .state(state)
    );

    microStore uStore (.state(state), .opcode(opcode), .ctrl(ctrl));

    iterTimer uTimer (
        .clk(clk), .reset(reset), .load(ctrl.timerLoad), .run(ctrl.timerRun),
        .last(timerLast)
    );

    regFile uRegs (
        .clk(clk), .reset(reset), .writeEn(ctrl.regWrite), .writeIdx(ir.dest),
        .readIdxA(ir.srcA), .readIdxB(ir.srcB), .writeData(aluResult),
        .readDataA(readDataA), .readDataB(readDataB)
    );

    aluUnit uAlu (
        .clk(clk), .reset(reset), .aluOp(ctrl.aluOp), .accClear(ctrl.accClear),
        .mulStep(ctrl.mulStep), .operandA(readDataA), .operandB(readDataB),
        .imm(ir.imm), .aluResult(aluResult)
    );

    assign busy = ctrl.busy;
    assign done = ctrl.done;

    // done without a write can only come from the illegal state
    assign result = '{
        written: ctrl.regWrite,
        illegal: ctrl.done & ~ctrl.regWrite,
        dest:    ir.dest,
        data:    aluResult
    };

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk
);

    initial clk = 1'b0;

    // 4 ns period
    always #2 clk = ~clk;

endmodule

// File: controlCore_assert.sv
`timescale 1ns/1ps

module controlCore_assert (
    input logic              clk,
    input logic              reset,
    input logic              busy,
    input logic              done,
    input dataPkg::wbResultT result
);

    // done is a single-cycle strobe
    doneOneCycle: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done stayed high for more than one cycle");

    doneWhileBusy: assert property (@(posedge clk) disable iff (reset) done |-> busy)
        else $error("done seen while busy was low");

    // core is back in idle right after writeback
    busyDropsAfterDone: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
        else $error("busy still high on the cycle after done");

    // flags only show up in the done cycle, and never together
    illegalNotWritten: assert property (@(posedge clk) disable iff (reset)
        (result.illegal || result.written) |-> (done && !(result.illegal && result.written)))
        else $error("result flags set outside done or both set");

endmodule

bind controlCore controlCore_assert coreChecks (
    .clk(clk), .reset(reset), .busy(busy), .done(done), .result(result)
);

// File: controlCore_tb.sv
`timescale 1ns/1ps

module controlCore_tb;

    import dataPkg::*;
    import ctrlPkg::*;

    localparam int DONE_TIMEOUT = 40;

    typedef struct {
        instrT    instr;
        int       pulseAt;
        wbResultT expResult;
        int       latency;
    } entryT;

    logic     clk;
    logic     reset;
    logic     start;
    instrT    instr;
    logic     busy;
    logic     done;
    wbResultT result;

    entryT                 tests[$];
    logic [DATA_WIDTH-1:0] modelRegs [REG_COUNT];

    tbClock clockGen (.clk(clk));

    controlCore DUT (
        .clk(clk), .reset(reset), .start(start), .instr(instr),
        .busy(busy), .done(done), .result(result)
    );

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic checkLevel(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    task automatic checkLatency(input int got, input int exp);
        if (got != exp) begin
            abortRun($sformatf("Error: latency is %h cycles, expected %h", got, exp));
        end
    endtask

    // data only matters when a register was written
    task automatic checkResult(input wbResultT got, input wbResultT exp);
        if (got.written !== exp.written || got.illegal !== exp.illegal ||
                got.dest !== exp.dest || (exp.written && got.data !== exp.data)) begin
            abortRun($sformatf("Error: result is %h, expected %h", got, exp));
        end
    endtask

    task automatic addEntry(input logic [3:0] op, input regIdxT dest, input regIdxT srcA,
                            input regIdxT srcB, input logic [5:0] imm, input int pulseAt);
        entryT e;
        e.instr = '{opcode: op, dest: dest, srcA: srcA, srcB: srcB, imm: imm};
        e.pulseAt = pulseAt;
        e.expResult = '0;
        e.latency = 0;
        tests.push_back(e);
    endtask

    // reference model with its own register copy
    task automatic predict(input int idx);
        instrT                 ins;
        logic                  legal;
        logic [DATA_WIDTH-1:0] a;
        logic [DATA_WIDTH-1:0] b;
        logic [DATA_WIDTH-1:0] value;
        ins = tests[idx].instr;
        a = modelRegs[ins.srcA];
        b = modelRegs[ins.srcB];
        value = '0;
        legal = 1'b1;
        tests[idx].latency = 4;
        case (opcodeT'(ins.opcode))
            OP_ADD: value = a + b;
            OP_SUB: value = a - b;
            OP_AND: value = a & b;
            OP_OR:  value = a | b;
            OP_LDI: value = DATA_WIDTH'(ins.imm);
            // low half of the product only
            OP_MUL: begin
                value = a * b;
                tests[idx].latency = 4 + MUL_STEPS;
            end
            default: begin
                legal = 1'b0;
                tests[idx].latency = 3;
            end
        endcase
        if (legal) begin
            tests[idx].expResult = '{written: 1'b1, illegal: 1'b0, dest: ins.dest, data: value};
            modelRegs[ins.dest] = value;
        end else begin
            tests[idx].expResult = '{written: 1'b0, illegal: 1'b1, dest: ins.dest, data: '0};
        end
    endtask

    task automatic runEntry(input int idx);
        int cycles;
        cycles = 0;
        @(posedge clk);
        instr <= tests[idx].instr;
        start <= 1'b1;
        @(negedge clk);
        checkLevel("busy", busy, 1'b0);
        checkLevel("done", done, 1'b0);
        while (done !== 1'b1) begin
            if (cycles >= DONE_TIMEOUT) begin
                abortRun($sformatf("Timeout: no done within %0d cycles for entry %0d",
                                   DONE_TIMEOUT, idx));
            end
            @(posedge clk);
            cycles++;
            // optional extra pulse lands while the core is busy
            start <= (cycles == tests[idx].pulseAt);
            @(negedge clk);
        end
        checkLatency(cycles, tests[idx].latency);
        checkLevel("busy", busy, 1'b1);
        checkResult(result, tests[idx].expResult);
        if (tests[idx].pulseAt != 0) begin
            for (int i = 0; i < 24; i++) begin
                @(negedge clk);
                checkLevel("done", done, 1'b0);
            end
        end
    endtask

    initial begin
        logic [15:0] rnd;
        void'($urandom(94837));
        reset = 1'b1;
        start = 1'b0;
        instr = '0;
        addEntry(OP_OR,  2'd0, 2'd0, 2'd0, 6'h00, 0);
        addEntry(OP_LDI, 2'd0, 2'd0, 2'd0, 6'h2D, 0);
        addEntry(OP_LDI, 2'd1, 2'd0, 2'd0, 6'h3F, 0);
        addEntry(OP_LDI, 2'd2, 2'd0, 2'd0, 6'h05, 0);
        addEntry(OP_LDI, 2'd3, 2'd0, 2'd0, 6'h00, 0);
        addEntry(OP_ADD, 2'd2, 2'd0, 2'd1, 6'h00, 0);
        // 0 minus r1 wraps around
        addEntry(OP_SUB, 2'd3, 2'd3, 2'd1, 6'h00, 0);
        addEntry(OP_AND, 2'd0, 2'd3, 2'd0, 6'h00, 0);
        addEntry(OP_OR,  2'd1, 2'd1, 2'd3, 6'h00, 0);
        addEntry(OP_MUL, 2'd2, 2'd2, 2'd3, 6'h00, 0);
        addEntry(OP_MUL, 2'd0, 2'd1, 2'd1, 6'h00, 0);
        addEntry(OP_LDI, 2'd3, 2'd0, 2'd0, 6'h00, 0);
        addEntry(OP_MUL, 2'd2, 2'd1, 2'd3, 6'h00, 0);
        addEntry(OP_MUL, 2'd3, 2'd2, 2'd1, 6'h00, 6);
        // illegal opcodes, then read back the target
        addEntry(4'd6,   2'd0, 2'd1, 2'd2, 6'h11, 0);
        addEntry(OP_OR,  2'd0, 2'd0, 2'd0, 6'h00, 0);
        addEntry(4'hF,   2'd3, 2'd0, 2'd1, 6'h3F, 0);
        addEntry(OP_OR,  2'd3, 2'd3, 2'd3, 6'h00, 0);
        addEntry(OP_ADD, 2'd1, 2'd0, 2'd2, 6'h00, 2);
        for (int i = 0; i < 24; i++) begin
            rnd = 16'($urandom());
            addEntry(rnd[15:12], rnd[11:10], rnd[9:8], rnd[7:6], rnd[5:0], 0);
        end
        for (int i = 0; i < REG_COUNT; i++) begin
            modelRegs[i] = '0;
        end
        foreach (tests[i]) begin
            predict(i);
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        foreach (tests[i]) begin
            runEntry(i);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// File: controlCore.f
dataPkg.sv
ctrlPkg.sv
microStore.sv
microSequencer.sv
iterTimer.sv
regFile.sv
aluUnit.sv
controlCore.sv
tbClock.sv
controlCore_assert.sv
controlCore_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = controlCore_tb
FILELIST  = controlCore.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
